// ==== compile.f ====
+incdir+.
desc_fetch_pkg.sv
desc_fetch_ctrl.sv
desc_qinfo_table.sv
desc_dma_fetch.sv
desc_fetch_top.sv
tb_desc_fetch.sv

// ==== desc_dma_fetch.sv ====
`timescale 1ns/1ps
`include "desc_fetch_defines.svh"

module desc_dma_fetch
  import desc_fetch_pkg::*;
#(
  parameter int table_depth = 16,
  localparam int ptr_w = $clog2(table_depth) + 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dma_addr_t                  fetch_queue_addr,
  input  logic                       desc_wr_en,
  input  logic [ptr_w-1:0]           fetch_finish_ptr,
  input  dma_data_t                  desc_dma_rsp_data,
  input  logic [ptr_w-1:0]           finish_ptr,
  output logic [`DMA_HEAD_WIDTH-1:0] desc_dma_req_head,
  output eth_len_t                   desc_rsp_length,
  output dma_addr_t                  desc_rsp_dma_addr,
  output csum_t                      desc_rsp_csum_start,
  output csum_t                      desc_rsp_csum_offset
);

  localparam int head_len_w = `HEAD_LEN_MSB - `HEAD_LEN_LSB + 1;

  dma_addr_t buf_addr_mem    [table_depth];
  eth_len_t  len_mem         [table_depth];
  csum_t     csum_start_mem  [table_depth];
  csum_t     csum_offset_mem [table_depth];

  // read header, queue address plus fixed byte length
  always_comb begin
    desc_dma_req_head = '0;
    desc_dma_req_head[`HEAD_ADDR_MSB:`HEAD_ADDR_LSB] = fetch_queue_addr;
    desc_dma_req_head[`HEAD_LEN_MSB:`HEAD_LEN_LSB]   = head_len_w'(`DESC_BYTES);
  end

  //********************************************************************
  // descriptor parse and store
  //********************************************************************

  // skipped entries leave their slot untouched
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < table_depth; i++) begin
        buf_addr_mem[i]    <= '0;
        len_mem[i]         <= '0;
        csum_start_mem[i]  <= '0;
        csum_offset_mem[i] <= '0;
      end
    end else if (desc_wr_en) begin
      buf_addr_mem[fetch_finish_ptr[ptr_w-2:0]] <=
        desc_dma_rsp_data[`DESC_BUF_ADDR_MSB:`DESC_BUF_ADDR_LSB];
      len_mem[fetch_finish_ptr[ptr_w-2:0]] <=
        desc_dma_rsp_data[`DESC_LEN_MSB:`DESC_LEN_LSB];
      csum_start_mem[fetch_finish_ptr[ptr_w-2:0]] <=
        desc_dma_rsp_data[`DESC_CSUM_START_MSB:`DESC_CSUM_START_LSB];
      csum_offset_mem[fetch_finish_ptr[ptr_w-2:0]] <=
        desc_dma_rsp_data[`DESC_CSUM_OFFSET_MSB:`DESC_CSUM_OFFSET_LSB];
    end
  end

  assign desc_rsp_dma_addr    = buf_addr_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_length      = len_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_csum_start  = csum_start_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_csum_offset = csum_offset_mem[finish_ptr[ptr_w-2:0]];

endmodule

// ==== desc_fetch_ctrl.sv ====
`timescale 1ns/1ps

module desc_fetch_ctrl
  import desc_fetch_pkg::*;
#(
  parameter int table_depth = 16,
  localparam int ptr_w = $clog2(table_depth) + 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             desc_req_valid,
  input  logic             desc_dequeue_req_ready,
  input  logic             desc_dequeue_resp_valid,
  input  logic             desc_dma_req_ready,
  input  logic             desc_dma_rsp_valid,
  input  logic             desc_rsp_ready,
  input  desc_status_e     fetch_start_status,
  input  desc_status_e     fetch_finish_status,
  output logic             desc_req_ready,
  output logic             desc_dequeue_req_valid,
  output logic             desc_dma_req_valid,
  output logic             desc_dma_rsp_ready,
  output logic             desc_rsp_valid,
  output logic [ptr_w-1:0] start_ptr,
  output logic [ptr_w-1:0] dequeue_ptr,
  output logic [ptr_w-1:0] info_ptr,
  output logic [ptr_w-1:0] fetch_start_ptr,
  output logic [ptr_w-1:0] fetch_finish_ptr,
  output logic [ptr_w-1:0] finish_ptr,
  output logic             req_wr_en,
  output logic             info_wr_en,
  output logic             desc_wr_en,
  output cnt_t             desc_fetch_req_cnt,
  output cnt_t             desc_fetch_rsp_cnt,
  output cnt_t             desc_fetch_error_cnt
);

  logic [ptr_w-1:0] live_cnt;
  logic             dequeue_en;
  logic             fetch_pending;
  logic             fetch_skip;
  logic             fetch_start_en;
  logic             finish_pending;
  logic             finish_skip;
  logic             rsp_en;

  //********************************************************************
  // handshake decisions
  //********************************************************************

  // table is full once the live count reaches the depth
  assign live_cnt       = start_ptr - finish_ptr;
  assign desc_req_ready = live_cnt < ptr_w'(table_depth);
  assign req_wr_en      = desc_req_valid && desc_req_ready;

  assign desc_dequeue_req_valid = dequeue_ptr != start_ptr;
  assign dequeue_en             = desc_dequeue_req_valid && desc_dequeue_req_ready;

  // queue manager answers in order, one entry per pulse
  assign info_wr_en = desc_dequeue_resp_valid;

  // issue side of the dma read, error entries step over it
  assign fetch_pending      = fetch_start_ptr != info_ptr;
  assign fetch_skip         = fetch_pending && (fetch_start_status == STATUS_ERR);
  assign desc_dma_req_valid = fetch_pending && !fetch_skip;
  assign fetch_start_en     = (desc_dma_req_valid && desc_dma_req_ready) || fetch_skip;

  // completion side, oldest outstanding entry only
  assign finish_pending     = fetch_finish_ptr != fetch_start_ptr;
  assign finish_skip        = finish_pending && (fetch_finish_status == STATUS_ERR);
  assign desc_dma_rsp_ready = finish_pending && !finish_skip;
  assign desc_wr_en         = desc_dma_rsp_valid && desc_dma_rsp_ready;

  assign desc_rsp_valid = finish_ptr != fetch_finish_ptr;
  assign rsp_en         = desc_rsp_valid && desc_rsp_ready;

  //********************************************************************
  // circular table pointers
  //********************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_ptr        <= '0;
      dequeue_ptr      <= '0;
      info_ptr         <= '0;
      fetch_start_ptr  <= '0;
      fetch_finish_ptr <= '0;
      finish_ptr       <= '0;
    end else begin
      if (req_wr_en) begin
        start_ptr <= start_ptr + 1'b1;
      end
      if (dequeue_en) begin
        dequeue_ptr <= dequeue_ptr + 1'b1;
      end
      if (info_wr_en) begin
        info_ptr <= info_ptr + 1'b1;
      end
      if (fetch_start_en) begin
        fetch_start_ptr <= fetch_start_ptr + 1'b1;
      end
      if (desc_wr_en || finish_skip) begin
        fetch_finish_ptr <= fetch_finish_ptr + 1'b1;
      end
      if (rsp_en) begin
        finish_ptr <= finish_ptr + 1'b1;
      end
    end
  end

  // statistics
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desc_fetch_req_cnt   <= '0;
      desc_fetch_rsp_cnt   <= '0;
      desc_fetch_error_cnt <= '0;
    end else begin
      if (dequeue_en) begin
        desc_fetch_req_cnt <= desc_fetch_req_cnt + 1'b1;
      end
      if (rsp_en) begin
        desc_fetch_rsp_cnt <= desc_fetch_rsp_cnt + 1'b1;
      end
      if (fetch_skip) begin
        desc_fetch_error_cnt <= desc_fetch_error_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== desc_fetch_defines.svh ====
`ifndef DESC_FETCH_DEFINES_SVH
`define DESC_FETCH_DEFINES_SVH

// field widths
`define QUEUE_NUMBER_WIDTH 8
`define QUEUE_INDEX_WIDTH  16
`define DMA_ADDR_WIDTH     64
`define STATUS_WIDTH       8
`define ETH_LEN_WIDTH      16
`define CSUM_WIDTH         8
`define DMA_HEAD_WIDTH     128
`define DMA_DATA_WIDTH     128
`define CNT_WIDTH          32

// bytes read per descriptor
`define DESC_BYTES 16

// descriptor layout in the dma data word
`define DESC_BUF_ADDR_MSB    127
`define DESC_BUF_ADDR_LSB    64
`define DESC_LEN_MSB         47
`define DESC_LEN_LSB         32
`define DESC_CSUM_OFFSET_MSB 31
`define DESC_CSUM_OFFSET_LSB 24
`define DESC_CSUM_START_MSB  23
`define DESC_CSUM_START_LSB  16

// dma read header, all other bits zero
`define HEAD_ADDR_MSB 95
`define HEAD_ADDR_LSB 32
`define HEAD_LEN_MSB  12
`define HEAD_LEN_LSB  0

`endif

// ==== desc_fetch_pkg.sv ====
`include "desc_fetch_defines.svh"

package desc_fetch_pkg;

  // queue manager status
  // only zero means error, every other value is treated as fetch
  typedef enum logic [`STATUS_WIDTH-1:0] {
    STATUS_ERR = 'h00,
    STATUS_OK  = 'hff
  } desc_status_e;

  typedef logic [`QUEUE_NUMBER_WIDTH-1:0] qnum_t;
  typedef logic [`QUEUE_INDEX_WIDTH-1:0]  qindex_t;
  typedef logic [`DMA_ADDR_WIDTH-1:0]     dma_addr_t;
  typedef logic [`ETH_LEN_WIDTH-1:0]      eth_len_t;
  typedef logic [`CSUM_WIDTH-1:0]         csum_t;
  typedef logic [`DMA_DATA_WIDTH-1:0]     dma_data_t;
  typedef logic [`CNT_WIDTH-1:0]          cnt_t;

endpackage

// ==== desc_fetch_top.sv ====
`timescale 1ns/1ps
`include "desc_fetch_defines.svh"

module desc_fetch_top
  import desc_fetch_pkg::*;
#(
  parameter int table_depth = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // requester
  input  logic                       desc_req_valid,
  input  qnum_t                      desc_req_qnum,
  output logic                       desc_req_ready,
  // queue manager
  output logic                       desc_dequeue_req_valid,
  output qnum_t                      desc_dequeue_req_qnum,
  input  logic                       desc_dequeue_req_ready,
  input  logic                       desc_dequeue_resp_valid,
  input  qindex_t                    desc_dequeue_resp_qindex,
  input  dma_addr_t                  desc_dequeue_resp_desc_addr,
  input  dma_addr_t                  desc_dequeue_resp_cpl_addr,
  input  logic [`STATUS_WIDTH-1:0]   desc_dequeue_resp_status,
  // dma read
  output logic                       desc_dma_req_valid,
  output logic [`DMA_HEAD_WIDTH-1:0] desc_dma_req_head,
  input  logic                       desc_dma_req_ready,
  input  logic                       desc_dma_rsp_valid,
  input  dma_data_t                  desc_dma_rsp_data,
  output logic                       desc_dma_rsp_ready,
  // assembled descriptor back to the requester
  output logic                       desc_rsp_valid,
  output logic [`STATUS_WIDTH-1:0]   desc_rsp_status,
  output qnum_t                      desc_rsp_qnum,
  output qindex_t                    desc_rsp_qindex,
  output eth_len_t                   desc_rsp_length,
  output dma_addr_t                  desc_rsp_dma_addr,
  output dma_addr_t                  desc_rsp_desc_addr,
  output csum_t                      desc_rsp_csum_start,
  output csum_t                      desc_rsp_csum_offset,
  output dma_addr_t                  desc_rsp_cpl_addr,
  input  logic                       desc_rsp_ready,
  // statistics
  output cnt_t                       desc_fetch_req_cnt,
  output cnt_t                       desc_fetch_rsp_cnt,
  output cnt_t                       desc_fetch_error_cnt
);

  localparam int ptr_w = $clog2(table_depth) + 1;

  logic [ptr_w-1:0] start_ptr;
  logic [ptr_w-1:0] dequeue_ptr;
  logic [ptr_w-1:0] info_ptr;
  logic [ptr_w-1:0] fetch_start_ptr;
  logic [ptr_w-1:0] fetch_finish_ptr;
  logic [ptr_w-1:0] finish_ptr;
  logic             req_wr_en;
  logic             info_wr_en;
  logic             desc_wr_en;
  desc_status_e     fetch_start_status;
  desc_status_e     fetch_finish_status;
  dma_addr_t        fetch_queue_addr;

  desc_fetch_ctrl #(
    .table_depth(table_depth)
  ) i_desc_fetch_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .desc_req_valid         (desc_req_valid),
    .desc_dequeue_req_ready (desc_dequeue_req_ready),
    .desc_dequeue_resp_valid(desc_dequeue_resp_valid),
    .desc_dma_req_ready     (desc_dma_req_ready),
    .desc_dma_rsp_valid     (desc_dma_rsp_valid),
    .desc_rsp_ready         (desc_rsp_ready),
    .fetch_start_status     (fetch_start_status),
    .fetch_finish_status    (fetch_finish_status),
    .desc_req_ready         (desc_req_ready),
    .desc_dequeue_req_valid (desc_dequeue_req_valid),
    .desc_dma_req_valid     (desc_dma_req_valid),
    .desc_dma_rsp_ready     (desc_dma_rsp_ready),
    .desc_rsp_valid         (desc_rsp_valid),
    .start_ptr              (start_ptr),
    .dequeue_ptr            (dequeue_ptr),
    .info_ptr               (info_ptr),
    .fetch_start_ptr        (fetch_start_ptr),
    .fetch_finish_ptr       (fetch_finish_ptr),
    .finish_ptr             (finish_ptr),
    .req_wr_en              (req_wr_en),
    .info_wr_en             (info_wr_en),
    .desc_wr_en             (desc_wr_en),
    .desc_fetch_req_cnt     (desc_fetch_req_cnt),
    .desc_fetch_rsp_cnt     (desc_fetch_rsp_cnt),
    .desc_fetch_error_cnt   (desc_fetch_error_cnt)
  );

  desc_qinfo_table #(
    .table_depth(table_depth)
  ) i_desc_qinfo_table (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .req_wr_en                  (req_wr_en),
    .start_ptr                  (start_ptr),
    .desc_req_qnum              (desc_req_qnum),
    .info_wr_en                 (info_wr_en),
    .info_ptr                   (info_ptr),
    .desc_dequeue_resp_qindex   (desc_dequeue_resp_qindex),
    .desc_dequeue_resp_desc_addr(desc_dequeue_resp_desc_addr),
    .desc_dequeue_resp_cpl_addr (desc_dequeue_resp_cpl_addr),
    .desc_dequeue_resp_status   (desc_dequeue_resp_status),
    .dequeue_ptr                (dequeue_ptr),
    .fetch_start_ptr            (fetch_start_ptr),
    .fetch_finish_ptr           (fetch_finish_ptr),
    .finish_ptr                 (finish_ptr),
    .desc_dequeue_req_qnum      (desc_dequeue_req_qnum),
    .fetch_queue_addr           (fetch_queue_addr),
    .fetch_start_status         (fetch_start_status),
    .fetch_finish_status        (fetch_finish_status),
    .desc_rsp_status            (desc_rsp_status),
    .desc_rsp_qnum              (desc_rsp_qnum),
    .desc_rsp_qindex            (desc_rsp_qindex),
    .desc_rsp_desc_addr         (desc_rsp_desc_addr),
    .desc_rsp_cpl_addr          (desc_rsp_cpl_addr)
  );

  desc_dma_fetch #(
    .table_depth(table_depth)
  ) i_desc_dma_fetch (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_queue_addr    (fetch_queue_addr),
    .desc_wr_en          (desc_wr_en),
    .fetch_finish_ptr    (fetch_finish_ptr),
    .desc_dma_rsp_data   (desc_dma_rsp_data),
    .finish_ptr          (finish_ptr),
    .desc_dma_req_head   (desc_dma_req_head),
    .desc_rsp_length     (desc_rsp_length),
    .desc_rsp_dma_addr   (desc_rsp_dma_addr),
    .desc_rsp_csum_start (desc_rsp_csum_start),
    .desc_rsp_csum_offset(desc_rsp_csum_offset)
  );

endmodule

// ==== desc_qinfo_table.sv ====
`timescale 1ns/1ps
`include "desc_fetch_defines.svh"

module desc_qinfo_table
  import desc_fetch_pkg::*;
#(
  parameter int table_depth = 16,
  localparam int ptr_w = $clog2(table_depth) + 1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_wr_en,
  input  logic [ptr_w-1:0]         start_ptr,
  input  qnum_t                    desc_req_qnum,
  input  logic                     info_wr_en,
  input  logic [ptr_w-1:0]         info_ptr,
  input  qindex_t                  desc_dequeue_resp_qindex,
  input  dma_addr_t                desc_dequeue_resp_desc_addr,
  input  dma_addr_t                desc_dequeue_resp_cpl_addr,
  input  logic [`STATUS_WIDTH-1:0] desc_dequeue_resp_status,
  input  logic [ptr_w-1:0]         dequeue_ptr,
  input  logic [ptr_w-1:0]         fetch_start_ptr,
  input  logic [ptr_w-1:0]         fetch_finish_ptr,
  input  logic [ptr_w-1:0]         finish_ptr,
  output qnum_t                    desc_dequeue_req_qnum,
  output dma_addr_t                fetch_queue_addr,
  output desc_status_e             fetch_start_status,
  output desc_status_e             fetch_finish_status,
  output logic [`STATUS_WIDTH-1:0] desc_rsp_status,
  output qnum_t                    desc_rsp_qnum,
  output qindex_t                  desc_rsp_qindex,
  output dma_addr_t                desc_rsp_desc_addr,
  output dma_addr_t                desc_rsp_cpl_addr
);

  qnum_t                    qnum_mem      [table_depth];
  qindex_t                  qindex_mem    [table_depth];
  dma_addr_t                desc_addr_mem [table_depth];
  dma_addr_t                cpl_addr_mem  [table_depth];
  logic [`STATUS_WIDTH-1:0] status_mem    [table_depth];

  // queue number, written at request time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < table_depth; i++) begin
        qnum_mem[i] <= '0;
      end
    end else if (req_wr_en) begin
      qnum_mem[start_ptr[ptr_w-2:0]] <= desc_req_qnum;
    end
  end

  // queue manager info, written as each response arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < table_depth; i++) begin
        qindex_mem[i]    <= '0;
        desc_addr_mem[i] <= '0;
        cpl_addr_mem[i]  <= '0;
        status_mem[i]    <= '0;
      end
    end else if (info_wr_en) begin
      qindex_mem[info_ptr[ptr_w-2:0]]    <= desc_dequeue_resp_qindex;
      desc_addr_mem[info_ptr[ptr_w-2:0]] <= desc_dequeue_resp_desc_addr;
      cpl_addr_mem[info_ptr[ptr_w-2:0]]  <= desc_dequeue_resp_cpl_addr;
      status_mem[info_ptr[ptr_w-2:0]]    <= desc_dequeue_resp_status;
    end
  end

  //********************************************************************
  // read ports at the control pointers
  //********************************************************************

  assign desc_dequeue_req_qnum = qnum_mem[dequeue_ptr[ptr_w-2:0]];
  assign fetch_queue_addr      = desc_addr_mem[fetch_start_ptr[ptr_w-2:0]];
  assign fetch_start_status    = desc_status_e'(status_mem[fetch_start_ptr[ptr_w-2:0]]);
  assign fetch_finish_status   = desc_status_e'(status_mem[fetch_finish_ptr[ptr_w-2:0]]);

  assign desc_rsp_status    = status_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_qnum      = qnum_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_qindex    = qindex_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_desc_addr = desc_addr_mem[finish_ptr[ptr_w-2:0]];
  assign desc_rsp_cpl_addr  = cpl_addr_mem[finish_ptr[ptr_w-2:0]];

endmodule

// ==== tb_desc_fetch.sv ====
`timescale 1ns/1ps
`include "desc_fetch_defines.svh"

module tb_desc_fetch
  import desc_fetch_pkg::*;
();

  localparam int n_random   = 300;
  localparam int max_cycles = n_random * 60 + 2000;

  typedef struct packed {
    qindex_t    qindex;
    dma_addr_t  desc_addr;
    dma_addr_t  cpl_addr;
    logic [7:0] status;
    eth_len_t   length;
    dma_addr_t  dma_addr;
    csum_t      csum_start;
    csum_t      csum_offset;
  } exp_desc_t;

  logic clk;
  logic rst_n;
  logic desc_req_valid;
  logic desc_req_ready;
  logic desc_dequeue_req_valid;
  logic desc_dequeue_req_ready;
  logic desc_dequeue_resp_valid;
  logic desc_dma_req_valid;
  logic desc_dma_req_ready;
  logic desc_dma_rsp_valid;
  logic desc_dma_rsp_ready;
  logic desc_rsp_valid;
  logic desc_rsp_ready;
  qnum_t desc_req_qnum;
  qnum_t desc_dequeue_req_qnum;
  qnum_t desc_rsp_qnum;
  qindex_t desc_dequeue_resp_qindex;
  qindex_t desc_rsp_qindex;
  dma_addr_t desc_dequeue_resp_desc_addr;
  dma_addr_t desc_dequeue_resp_cpl_addr;
  dma_addr_t desc_rsp_dma_addr;
  dma_addr_t desc_rsp_desc_addr;
  dma_addr_t desc_rsp_cpl_addr;
  logic [7:0] desc_dequeue_resp_status;
  logic [7:0] desc_rsp_status;
  logic [127:0] desc_dma_req_head;
  dma_data_t desc_dma_rsp_data;
  eth_len_t desc_rsp_length;
  csum_t desc_rsp_csum_start;
  csum_t desc_rsp_csum_offset;
  cnt_t desc_fetch_req_cnt;
  cnt_t desc_fetch_rsp_cnt;
  cnt_t desc_fetch_error_cnt;

  integer seed = 67486;
  int cycle_cnt;
  int qm_taken;
  int rsp_seen;
  int err_expected;
  int rsp_mode;
  logic qm_bp;
  logic dma_bp;
  logic rsp_pulse;
  logic qm_take;
  logic dma_take;
  logic dma_done;
  logic next_rsp_ready;
  qnum_t qm_qnum;
  exp_desc_t qm_info;
  logic [127:0] dma_head;
  // expected order of responses, qm answers, and dma reads
  qnum_t exp_q[$];
  qnum_t qm_qnum_q[$];
  qnum_t dma_exp_q[$];
  int qm_due_q[$];
  int dma_due_q[$];
  dma_addr_t dma_addr_q[$];

  desc_fetch_top #(.table_depth(4)) i_desc_fetch_top (.*);

  //**********************************************************************
  // reference and checking
  //**********************************************************************

  function automatic exp_desc_t desc_model(input qnum_t qnum);
    exp_desc_t m;
    m.qindex      = qindex_t'(qnum) * 16'd3;
    m.desc_addr   = 64'h1000 + dma_addr_t'(qnum) * 64'h40;
    m.cpl_addr    = 64'h8000 + dma_addr_t'(qnum);
    m.status      = (qnum % 5 == 0) ? STATUS_ERR : STATUS_OK;
    m.dma_addr    = m.desc_addr + 64'h100000;
    m.length      = m.desc_addr[15:0] + 16'd64;
    m.csum_start  = 8'd14;
    m.csum_offset = 8'd16;
    return m;
  endfunction

  // descriptor word the dma model returns for a header address
  function automatic dma_data_t dma_word(input dma_addr_t addr);
    dma_data_t d;
    d = '0;
    d[127:64] = addr + 64'h100000;
    d[47:32]  = addr[15:0] + 16'd64;
    d[31:24]  = 8'd16;
    d[23:16]  = 8'd14;
    return d;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s (time %0t)", msg, $time);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, actual, expected);
      stop_on_error("value check failed");
    end
  endtask

  task automatic check_head(input logic [127:0] head);
    logic [127:0] exp_head;
    exp_desc_t    e;
    if (dma_exp_q.size() == 0) begin
      stop_on_error("DMA read issued with no fetch entry outstanding");
    end else begin
      e = desc_model(dma_exp_q.pop_front());
      exp_head = '0;
      exp_head[95:32] = e.desc_addr;
      exp_head[12:0]  = 13'd16;
      check_value(head, exp_head, "dma read header");
    end
  endtask

  task automatic compare_response();
    exp_desc_t e;
    qnum_t q;
    if (exp_q.size() == 0) begin
      stop_on_error("response returned with no request outstanding");
    end else begin
      q = exp_q.pop_front();
      e = desc_model(q);
      check_value(desc_rsp_qnum, q, "rsp qnum");
      check_value(desc_rsp_status, e.status, "rsp status");
      check_value(desc_rsp_qindex, e.qindex, "rsp qindex");
      check_value(desc_rsp_desc_addr, e.desc_addr, "rsp desc_addr");
      check_value(desc_rsp_cpl_addr, e.cpl_addr, "rsp cpl_addr");
      // descriptor fields are undefined for error entries
      if (e.status != STATUS_ERR) begin
        check_value(desc_rsp_length, e.length, "rsp length");
        check_value(desc_rsp_dma_addr, e.dma_addr, "rsp dma_addr");
        check_value(desc_rsp_csum_start, e.csum_start, "rsp csum_start");
        check_value(desc_rsp_csum_offset, e.csum_offset, "rsp csum_offset");
      end
      rsp_seen++;
    end
  endtask

  //**********************************************************************
  // clock, timeout and bus models
  //**********************************************************************

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt > max_cycles) begin
        stop_on_error("timeout, the DUT stopped returning responses");
      end
    end
  end

  // queue manager answers in order with one response pulse per cycle
  always begin
    @(negedge clk);
    qm_take = rst_n && desc_dequeue_req_valid && desc_dequeue_req_ready;
    qm_qnum = desc_dequeue_req_qnum;
    @(posedge clk);
    #2;
    if (qm_take) begin
      qm_taken++;
      qm_qnum_q.push_back(qm_qnum);
      qm_due_q.push_back(cycle_cnt + ($random(seed) & 3));
    end
    desc_dequeue_resp_valid = 1'b0;
    if (qm_due_q.size() > 0 && qm_due_q[0] <= cycle_cnt) begin
      void'(qm_due_q.pop_front());
      qm_qnum = qm_qnum_q.pop_front();
      qm_info = desc_model(qm_qnum);
      desc_dequeue_resp_valid     = 1'b1;
      desc_dequeue_resp_qindex    = qm_info.qindex;
      desc_dequeue_resp_desc_addr = qm_info.desc_addr;
      desc_dequeue_resp_cpl_addr  = qm_info.cpl_addr;
      desc_dequeue_resp_status    = qm_info.status;
      if (qm_info.status != STATUS_ERR) begin
        dma_exp_q.push_back(qm_qnum);
      end
    end
    desc_dequeue_req_ready = qm_bp ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // dma read model holds its data until accepted
  always begin
    @(negedge clk);
    dma_take = rst_n && desc_dma_req_valid && desc_dma_req_ready;
    dma_head = desc_dma_req_head;
    dma_done = rst_n && desc_dma_rsp_valid && desc_dma_rsp_ready;
    @(posedge clk);
    #2;
    if (dma_done) begin
      void'(dma_addr_q.pop_front());
      void'(dma_due_q.pop_front());
    end
    if (dma_take) begin
      check_head(dma_head);
      dma_addr_q.push_back(dma_head[95:32]);
      dma_due_q.push_back(cycle_cnt + ($random(seed) & 3));
    end
    desc_dma_rsp_valid = 1'b0;
    desc_dma_rsp_data  = '0;
    if (dma_addr_q.size() > 0 && dma_due_q[0] <= cycle_cnt) begin
      desc_dma_rsp_valid = 1'b1;
      desc_dma_rsp_data  = dma_word(dma_addr_q[0]);
    end
    desc_dma_req_ready = dma_bp ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // responses compared at the falling edge
  always begin
    @(negedge clk);
    if (rst_n && desc_rsp_valid && desc_rsp_ready) begin
      compare_response();
    end
    // mode 0 always ready, 1 random, 2 held low
    next_rsp_ready = (rsp_mode == 0) || (rsp_mode == 1 && ($random(seed) & 1));
    if (rsp_pulse) begin
      next_rsp_ready = 1'b1;
      rsp_pulse      = 1'b0;
    end
    @(posedge clk);
    #2;
    desc_rsp_ready = next_rsp_ready;
  end

  //**********************************************************************
  // stimulus
  //**********************************************************************

  task automatic send_req(input qnum_t qnum);
    logic      done;
    exp_desc_t e;
    done = 1'b0;
    desc_req_valid = 1'b1;
    desc_req_qnum  = qnum;
    while (!done) begin
      @(negedge clk);
      done = desc_req_ready;
      @(posedge clk);
      #2;
    end
    desc_req_valid = 1'b0;
    exp_q.push_back(qnum);
    e = desc_model(qnum);
    if (e.status == STATUS_ERR) begin
      err_expected++;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    desc_req_valid = 1'b0;
    desc_req_qnum = '0;
    desc_dequeue_req_ready = 1'b1;
    desc_dequeue_resp_valid = 1'b0;
    desc_dequeue_resp_qindex = '0;
    desc_dequeue_resp_desc_addr = '0;
    desc_dequeue_resp_cpl_addr = '0;
    desc_dequeue_resp_status = '0;
    desc_dma_req_ready = 1'b1;
    desc_dma_rsp_valid = 1'b0;
    desc_dma_rsp_data = '0;
    desc_rsp_ready = 1'b1;
    qm_bp = 1'b0;
    dma_bp = 1'b0;
    rsp_pulse = 1'b0;
    rsp_mode = 0;
    qm_taken = 0;
    rsp_seen = 0;
    err_expected = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(desc_req_ready, 1'b1, "req ready after reset");
    check_value({desc_dequeue_req_valid, desc_dma_req_valid, desc_dma_rsp_ready,
                 desc_rsp_valid}, 4'b0000, "valid outputs after reset");
    @(posedge clk);
    #2;
    // one fetch entry, then one error entry
    send_req(8'd7);
    wait_drain();
    send_req(8'd10);
    wait_drain();
    // fill the table with responses stalled
    rsp_mode = 2;
    for (int i = 0; i < 4; i++) begin
      send_req(qnum_t'(21 + i * 2));
      @(negedge clk);
      check_value(desc_req_ready, i < 3, "req ready while filling");
      @(posedge clk);
      #2;
    end
    while (!desc_rsp_valid) begin
      @(posedge clk);
      #2;
    end
    rsp_pulse = 1'b1;
    while (rsp_seen != 3) begin
      @(negedge clk);
    end
    @(negedge clk);
    check_value(desc_req_ready, 1'b1, "req ready after one response");
    @(posedge clk);
    #2;
    rsp_mode = 0;
    wait_drain();
    // random traffic with back-pressure everywhere
    qm_bp = 1'b1;
    dma_bp = 1'b1;
    rsp_mode = 1;
    for (int i = 0; i < n_random; i++) begin
      send_req(qnum_t'($random(seed)));
      repeat ($random(seed) & 1) begin
        @(posedge clk);
        #2;
      end
    end
    wait_drain();
    @(negedge clk);
    check_value(desc_fetch_req_cnt, qm_taken, "dequeue request counter");
    check_value(desc_fetch_rsp_cnt, rsp_seen, "response counter");
    check_value(desc_fetch_error_cnt, err_expected, "error counter");
    $display("NO ERRORS");
    $finish;
  end

endmodule
